// File: logic/paPkg.sv
package paPkg;

	//////////////////////////////
	// datapath widths
	//////////////////////////////
	localparam int DATA_WIDTH = 16;
	localparam int REG_ADDR_WIDTH = 5;
	localparam int OPCODE_WIDTH = 7;
	localparam int INSTR_WIDTH = 32;
	localparam int BUNDLE_WIDTH = 64;
	localparam int PC_WIDTH = 16;
	localparam int STATUS_WIDTH = 2;

	// cache geometry
	localparam int LINE_BYTES = 32;
	localparam int LINE_WIDTH = 256;
	localparam int LINE_ADDR_WIDTH = 8;
	localparam int BUNDLES_PER_LINE = 4;

	//////////////////////////////
	// slot field positions
	//////////////////////////////
	localparam int VALID_BIT = 31;
	// 0 reg-reg, 1 reg-imm
	localparam int FORMAT_BIT = 30;
	localparam int OPCODE_MSB = 29;
	localparam int OPCODE_LSB = 23;
	// primary is dest and first source
	localparam int PRIM_MSB = 20;
	localparam int PRIM_LSB = 16;
	// immediate, or source reg in low bits
	localparam int SEC_MSB = 15;
	localparam int SEC_LSB = 0;

	// opcodes, anything else acts as nop
	localparam logic [OPCODE_WIDTH-1:0] OP_NOP = 7'd0;
	localparam logic [OPCODE_WIDTH-1:0] OP_ADD = 7'd1;
	localparam logic [OPCODE_WIDTH-1:0] OP_SUB = 7'd2;
	localparam logic [OPCODE_WIDTH-1:0] OP_AND = 7'd3;
	localparam logic [OPCODE_WIDTH-1:0] OP_OR = 7'd4;
	localparam logic [OPCODE_WIDTH-1:0] OP_XOR = 7'd5;
	localparam logic [OPCODE_WIDTH-1:0] OP_MOVE = 7'd6;

	// status flags, overflow and borrow can both be set
	localparam logic [STATUS_WIDTH-1:0] STATUS_OK = 2'd0;
	localparam logic [STATUS_WIDTH-1:0] STATUS_UNDERFLOW = 2'd1;
	localparam logic [STATUS_WIDTH-1:0] STATUS_OVERFLOW = 2'd2;

	// top level defaults
	localparam int DEF_NUM_LANES = 2;
	localparam int DEF_WB_DEPTH = 8;
	localparam int DEF_CACHE_LINES = 256;

	// width of a lane number
	function automatic int laneIdxWidth(int lanes);
		return (lanes > 1) ? $clog2(lanes) : 1;
	endfunction

	// width of a bundle index into the whole cache
	function automatic int fetchIndexWidth(int cacheLines);
		return $clog2(cacheLines * BUNDLES_PER_LINE);
	endfunction

endpackage

// File: logic/cacheLoader.sv
`timescale 1ns/1ns

module cacheLoader
	import paPkg::*;
(
	input logic clock_i,
	input logic reset_i,
	input logic shiftEn_i,
	input logic [7:0] shiftData_i,
	input logic isAddress_i,
	input logic shiftOutEn_i,
	output logic lineWrite_o,
	output logic [LINE_ADDR_WIDTH-1:0] lineAddr_o,
	output logic [LINE_WIDTH-1:0] lineData_o
);

	localparam int BYTE_W = LINE_WIDTH / LINE_BYTES;

	// address byte and line shifter
	always_ff @(posedge clock_i)
	begin
		if (shiftEn_i)
		begin
			if (isAddress_i)
			begin
				lineAddr_o <= shiftData_i;
			end
			else
			begin
				// new byte enters at the top, oldest ends up in byte 0
				lineData_o <= {shiftData_i, lineData_o[LINE_WIDTH-1:BYTE_W]};
			end
		end
	end

	// commit pulse becomes a one cycle write strobe
	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			lineWrite_o <= 1'b0;
		end
		else
		begin
			lineWrite_o <= shiftOutEn_i;
		end
	end

endmodule

// File: logic/instrCache.sv
`timescale 1ns/1ns

module instrCache
	import paPkg::*;
#(
	parameter int CACHE_LINES = DEF_CACHE_LINES
)
(
	input logic clock_i,
	input logic lineWrite_i,
	input logic [LINE_ADDR_WIDTH-1:0] lineAddr_i,
	input logic [LINE_WIDTH-1:0] lineData_i,
	input logic [fetchIndexWidth(CACHE_LINES)-1:0] readIndex_i,
	output logic [BUNDLE_WIDTH-1:0] bundle_o
);

	localparam int IDX_W = fetchIndexWidth(CACHE_LINES);
	localparam int LINE_IDX_W = $clog2(CACHE_LINES);
	localparam int BSEL_W = $clog2(BUNDLES_PER_LINE);

	logic [LINE_WIDTH-1:0] cacheLines [CACHE_LINES];
	logic [LINE_IDX_W-1:0] readLine;
	logic [BSEL_W-1:0] readBundle;

	// upper index bits pick the line, low bits the bundle in it
	assign readLine = readIndex_i[IDX_W-1:BSEL_W];
	assign readBundle = readIndex_i[BSEL_W-1:0];

	// power-up contents zero, so unwritten lines hold invalid slots
	initial
	begin
		for (int l = 0; l < CACHE_LINES; l++)
		begin
			cacheLines[l] = '0;
		end
	end

	always_ff @(posedge clock_i)
	begin
		if (lineWrite_i)
		begin
			cacheLines[lineAddr_i[LINE_IDX_W-1:0]] <= lineData_i;
		end
		// read sees the old line on a same-cycle write
		bundle_o <= cacheLines[readLine][readBundle*BUNDLE_WIDTH +: BUNDLE_WIDTH];
	end

endmodule

// File: logic/bundleFetch.sv
`timescale 1ns/1ns

module bundleFetch
	import paPkg::*;
#(
	parameter int NUM_LANES = DEF_NUM_LANES,
	parameter int CACHE_LINES = DEF_CACHE_LINES
)
(
	input logic clock_i,
	input logic reset_i,
	input logic loading_i,
	input logic queueLow_i,
	input logic [BUNDLE_WIDTH-1:0] bundle_i,
	output logic [fetchIndexWidth(CACHE_LINES)-1:0] readIndex_o,
	output logic [PC_WIDTH-1:0] pc_o,
	output logic [NUM_LANES-1:0] slotValid_o,
	output logic [NUM_LANES*INSTR_WIDTH-1:0] slotInstr_o
);

	localparam int IDX_W = fetchIndexWidth(CACHE_LINES);
	localparam int PC_LAST = CACHE_LINES * BUNDLES_PER_LINE - 1;

	logic [PC_WIDTH-1:0] pc;
	// bundle now on bundle_i was consumed by a pc advance
	logic fetchLive;
	logic holdFetch;

	// stall on loading or queue back-pressure
	assign holdFetch = loading_i || queueLow_i;

	//////////////////////////////
	// program counter
	//////////////////////////////
	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			pc <= '0;
			fetchLive <= 1'b0;
		end
		else
		begin
			fetchLive <= !holdFetch;
			if (!holdFetch)
			begin
				// wrap at end of cache
				pc <= (pc == PC_WIDTH'(PC_LAST)) ? '0 : pc + 1'b1;
			end
		end
	end

	assign readIndex_o = pc[IDX_W-1:0];
	assign pc_o = pc;

	// slot 0 is the low word of the bundle
	always_comb
	begin
		for (int i = 0; i < NUM_LANES; i++)
		begin
			slotInstr_o[i*INSTR_WIDTH +: INSTR_WIDTH] = bundle_i[i*INSTR_WIDTH +: INSTR_WIDTH];
			slotValid_o[i] = fetchLive && bundle_i[i*INSTR_WIDTH + VALID_BIT];
		end
	end

endmodule

// File: logic/execLane.sv
`timescale 1ns/1ns

module execLane
	import paPkg::*;
(
	input logic clock_i,
	input logic reset_i,
	input logic slotValid_i,
	input logic [INSTR_WIDTH-1:0] slotInstr_i,
	output logic laneWb_o,
	output logic [REG_ADDR_WIDTH-1:0] laneAddr_o,
	output logic [DATA_WIDTH-1:0] laneData_o,
	output logic [STATUS_WIDTH-1:0] laneStatus_o
);

	localparam int REG_COUNT = 2 ** REG_ADDR_WIDTH;
	localparam int MSB = DATA_WIDTH - 1;

	// private register bank of this lane
	logic [DATA_WIDTH-1:0] regBank [REG_COUNT];

	logic immFormat;
	logic [OPCODE_WIDTH-1:0] opcode;
	logic [REG_ADDR_WIDTH-1:0] primReg;
	logic [DATA_WIDTH-1:0] secField;
	logic [DATA_WIDTH-1:0] opA;
	logic [DATA_WIDTH-1:0] opB;
	logic [DATA_WIDTH-1:0] result;
	logic [STATUS_WIDTH-1:0] status;
	logic overflow;
	logic underflow;
	logic isWriter;
	logic doWrite;

	//////////////////////////////
	// parse and operand read
	//////////////////////////////
	assign immFormat = slotInstr_i[FORMAT_BIT];
	assign opcode = slotInstr_i[OPCODE_MSB:OPCODE_LSB];
	assign primReg = slotInstr_i[PRIM_MSB:PRIM_LSB];
	assign secField = slotInstr_i[SEC_MSB:SEC_LSB];

	assign opA = regBank[primReg];
	// reg-reg uses low bits of the secondary as the source
	assign opB = immFormat ? secField : regBank[secField[REG_ADDR_WIDTH-1:0]];

	//////////////////////////////
	// execute
	//////////////////////////////
	always_comb
	begin
		result = opB;
		overflow = 1'b0;
		underflow = 1'b0;
		isWriter = 1'b1;
		case (opcode)
			OP_ADD:
			begin
				result = opA + opB;
				// same signs in, different sign out
				overflow = (opA[MSB] == opB[MSB]) && (result[MSB] != opA[MSB]);
			end
			OP_SUB:
			begin
				result = opA - opB;
				overflow = (opA[MSB] != opB[MSB]) && (result[MSB] != opA[MSB]);
				// unsigned borrow
				underflow = opA < opB;
			end
			OP_AND: result = opA & opB;
			OP_OR: result = opA | opB;
			OP_XOR: result = opA ^ opB;
			OP_MOVE: result = opB;
			// nop and unknown opcodes
			default: isWriter = 1'b0;
		endcase
	end

	assign status = (overflow ? STATUS_OVERFLOW : STATUS_OK)
		| (underflow ? STATUS_UNDERFLOW : STATUS_OK);
	assign doWrite = slotValid_i && isWriter;

	// bank write lands at the same edge as the lane outputs
	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			laneWb_o <= 1'b0;
			for (int r = 0; r < REG_COUNT; r++)
			begin
				regBank[r] <= '0;
			end
		end
		else
		begin
			laneWb_o <= doWrite;
			if (doWrite)
			begin
				regBank[primReg] <= result;
			end
		end
	end

	always_ff @(posedge clock_i)
	begin
		laneAddr_o <= primReg;
		laneData_o <= result;
		laneStatus_o <= status;
	end

endmodule

// File: logic/writebackQueue.sv
`timescale 1ns/1ns

module writebackQueue
	import paPkg::*;
#(
	parameter int NUM_LANES = DEF_NUM_LANES,
	parameter int WB_DEPTH = DEF_WB_DEPTH
)
(
	input logic clock_i,
	input logic reset_i,
	input logic [NUM_LANES-1:0] laneWb_i,
	input logic [NUM_LANES*REG_ADDR_WIDTH-1:0] laneAddr_i,
	input logic [NUM_LANES*DATA_WIDTH-1:0] laneData_i,
	input logic [NUM_LANES*STATUS_WIDTH-1:0] laneStatus_i,
	output logic queueLow_o,
	output logic wbValid_o,
	output logic [laneIdxWidth(NUM_LANES)-1:0] wbLane_o,
	output logic [REG_ADDR_WIDTH-1:0] wbAddr_o,
	output logic [DATA_WIDTH-1:0] wbData_o,
	output logic [STATUS_WIDTH-1:0] wbStatus_o
);

	localparam int LANE_W = laneIdxWidth(NUM_LANES);
	localparam int PTR_W = $clog2(WB_DEPTH);
	localparam int CNT_W = PTR_W + 1;

	// entry storage
	logic [LANE_W-1:0] memLane [WB_DEPTH];
	logic [REG_ADDR_WIDTH-1:0] memAddr [WB_DEPTH];
	logic [DATA_WIDTH-1:0] memData [WB_DEPTH];
	logic [STATUS_WIDTH-1:0] memStatus [WB_DEPTH];

	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] inCount;
	logic [CNT_W-1:0] slotOffset [NUM_LANES];
	logic [LANE_W-1:0] firstLane;
	logic pop;

	//////////////////////////////
	// packing of incoming results
	//////////////////////////////
	always_comb
	begin
		inCount = '0;
		firstLane = '0;
		// lower lanes take the earlier slots
		for (int i = 0; i < NUM_LANES; i++)
		begin
			slotOffset[i] = inCount;
			inCount = inCount + CNT_W'(laneWb_i[i]);
		end
		for (int i = NUM_LANES - 1; i >= 0; i--)
		begin
			if (laneWb_i[i])
			begin
				firstLane = LANE_W'(i);
			end
		end
	end

	// one out per cycle, from buffer or straight from the lanes when empty
	assign pop = (count != '0) || (inCount != '0);
	assign queueLow_o = (CNT_W'(WB_DEPTH) - count) < CNT_W'(2 * NUM_LANES);

	// every arrival is stored, an empty-queue bypass just skips past it
	always_ff @(posedge clock_i)
	begin
		for (int i = 0; i < NUM_LANES; i++)
		begin
			if (laneWb_i[i])
			begin
				memLane[wrPtr + PTR_W'(slotOffset[i])] <= LANE_W'(i);
				memAddr[wrPtr + PTR_W'(slotOffset[i])] <= laneAddr_i[i*REG_ADDR_WIDTH +: REG_ADDR_WIDTH];
				memData[wrPtr + PTR_W'(slotOffset[i])] <= laneData_i[i*DATA_WIDTH +: DATA_WIDTH];
				memStatus[wrPtr + PTR_W'(slotOffset[i])] <= laneStatus_i[i*STATUS_WIDTH +: STATUS_WIDTH];
			end
		end
	end

	//////////////////////////////
	// pointers and output
	//////////////////////////////
	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			wbValid_o <= 1'b0;
		end
		else
		begin
			wrPtr <= wrPtr + PTR_W'(inCount);
			rdPtr <= rdPtr + PTR_W'(pop);
			count <= count + inCount - CNT_W'(pop);
			wbValid_o <= pop;
		end
	end

	always_ff @(posedge clock_i)
	begin
		if (count != '0)
		begin
			wbLane_o <= memLane[rdPtr];
			wbAddr_o <= memAddr[rdPtr];
			wbData_o <= memData[rdPtr];
			wbStatus_o <= memStatus[rdPtr];
		end
		else
		begin
			wbLane_o <= firstLane;
			wbAddr_o <= laneAddr_i[firstLane*REG_ADDR_WIDTH +: REG_ADDR_WIDTH];
			wbData_o <= laneData_i[firstLane*DATA_WIDTH +: DATA_WIDTH];
			wbStatus_o <= laneStatus_i[firstLane*STATUS_WIDTH +: STATUS_WIDTH];
		end
	end

endmodule

// File: logic/paCore.sv
`timescale 1ns/1ns

module paCore
	import paPkg::*;
#(
	parameter int NUM_LANES = DEF_NUM_LANES,
	parameter int WB_DEPTH = DEF_WB_DEPTH,
	parameter int CACHE_LINES = DEF_CACHE_LINES
)
(
	input logic clock_i,
	input logic reset_i,
	input logic shiftEn_i,
	input logic [7:0] shiftData_i,
	input logic isAddress_i,
	input logic shiftOutEn_i,
	output logic [PC_WIDTH-1:0] PC_o,
	output logic wbValid_o,
	output logic [laneIdxWidth(NUM_LANES)-1:0] wbLane_o,
	output logic [REG_ADDR_WIDTH-1:0] wbAddr_o,
	output logic [DATA_WIDTH-1:0] wbData_o,
	output logic [STATUS_WIDTH-1:0] wbStatus_o
);

	// loader to cache
	logic lineWrite;
	logic [LINE_ADDR_WIDTH-1:0] lineAddr;
	logic [LINE_WIDTH-1:0] lineData;

	// cache and fetch
	logic [fetchIndexWidth(CACHE_LINES)-1:0] readIndex;
	logic [BUNDLE_WIDTH-1:0] bundle;
	logic [NUM_LANES-1:0] slotValid;
	logic [NUM_LANES*INSTR_WIDTH-1:0] slotInstr;

	// lanes to queue
	logic [NUM_LANES-1:0] laneWb;
	logic [NUM_LANES*REG_ADDR_WIDTH-1:0] laneAddr;
	logic [NUM_LANES*DATA_WIDTH-1:0] laneData;
	logic [NUM_LANES*STATUS_WIDTH-1:0] laneStatus;
	logic queueLow;

	cacheLoader loader (
		.clock_i(clock_i), .reset_i(reset_i),
		.shiftEn_i(shiftEn_i), .shiftData_i(shiftData_i),
		.isAddress_i(isAddress_i), .shiftOutEn_i(shiftOutEn_i),
		.lineWrite_o(lineWrite), .lineAddr_o(lineAddr), .lineData_o(lineData)
	);

	instrCache #(.CACHE_LINES(CACHE_LINES)) icache (
		.clock_i(clock_i),
		.lineWrite_i(lineWrite), .lineAddr_i(lineAddr), .lineData_i(lineData),
		.readIndex_i(readIndex), .bundle_o(bundle)
	);

	// fetch holds while loading
	bundleFetch #(.NUM_LANES(NUM_LANES), .CACHE_LINES(CACHE_LINES)) fetch (
		.clock_i(clock_i), .reset_i(reset_i),
		.loading_i(shiftEn_i), .queueLow_i(queueLow), .bundle_i(bundle),
		.readIndex_o(readIndex), .pc_o(PC_o),
		.slotValid_o(slotValid), .slotInstr_o(slotInstr)
	);

	//////////////////////////////
	// arithmetic lanes
	//////////////////////////////
	for (genvar g = 0; g < NUM_LANES; g++)
	begin : genLane
		execLane lane (
			.clock_i(clock_i), .reset_i(reset_i),
			.slotValid_i(slotValid[g]),
			.slotInstr_i(slotInstr[g*INSTR_WIDTH +: INSTR_WIDTH]),
			.laneWb_o(laneWb[g]),
			.laneAddr_o(laneAddr[g*REG_ADDR_WIDTH +: REG_ADDR_WIDTH]),
			.laneData_o(laneData[g*DATA_WIDTH +: DATA_WIDTH]),
			.laneStatus_o(laneStatus[g*STATUS_WIDTH +: STATUS_WIDTH])
		);
	end

	writebackQueue #(.NUM_LANES(NUM_LANES), .WB_DEPTH(WB_DEPTH)) wbQueue (
		.clock_i(clock_i), .reset_i(reset_i),
		.laneWb_i(laneWb), .laneAddr_i(laneAddr),
		.laneData_i(laneData), .laneStatus_i(laneStatus),
		.queueLow_o(queueLow), .wbValid_o(wbValid_o), .wbLane_o(wbLane_o),
		.wbAddr_o(wbAddr_o), .wbData_o(wbData_o), .wbStatus_o(wbStatus_o)
	);

endmodule

// File: tests/paCoreTb.sv
`timescale 1ns/1ns

module paCoreTb
	import paPkg::*;
;

	logic clock_i;
	logic reset_i;
	logic shiftEn_i;
	logic [7:0] shiftData_i;
	logic isAddress_i;
	logic shiftOutEn_i;
	logic [PC_WIDTH-1:0] PC_o;
	logic wbValid_o;
	logic [0:0] wbLane_o;
	logic [REG_ADDR_WIDTH-1:0] wbAddr_o;
	logic [DATA_WIDTH-1:0] wbData_o;
	logic [STATUS_WIDTH-1:0] wbStatus_o;

	// program image, lines 0 and 1
	logic [BUNDLE_WIDTH-1:0] prog [8];

	// expected results, bundle order then lane order
	logic expLane [64];
	logic [REG_ADDR_WIDTH-1:0] expAddr [64];
	logic [DATA_WIDTH-1:0] expData [64];
	logic [STATUS_WIDTH-1:0] expStatus [64];
	int expCount = 0;

	// monitor state
	int headIdx;
	int stallCycles;
	int ovfSeen;
	int brwSeen;
	logic [PC_WIDTH-1:0] lastPc;
	logic prevShift;
	int errors = 0;
	int nTests = 0;
	int passed = 0;

	paCore #(.NUM_LANES(2), .WB_DEPTH(8), .CACHE_LINES(256)) dut (
		.clock_i(clock_i), .reset_i(reset_i),
		.shiftEn_i(shiftEn_i), .shiftData_i(shiftData_i),
		.isAddress_i(isAddress_i), .shiftOutEn_i(shiftOutEn_i),
		.PC_o(PC_o), .wbValid_o(wbValid_o), .wbLane_o(wbLane_o),
		.wbAddr_o(wbAddr_o), .wbData_o(wbData_o), .wbStatus_o(wbStatus_o)
	);

	initial
	begin
		clock_i = 1'b0;
		forever #4 clock_i = ~clock_i;
	end

	// hard limit on the whole run
	initial
	begin
		#200000;
		$display("Error: simulation ran past its time limit");
		$display("TB FAILED");
		$finish;
	end

	task automatic noteFailure(input string msg);
		errors++;
		$display("Error at %0t: %s", $time, msg);
	endtask

	task automatic noteMismatch(input string msg);
		errors++;
		$display("Mismatch at %0t: %s", $time, msg);
	endtask

	//////////////////////////////
	// checks
	//////////////////////////////
	// pc cleared and no output right after a reset cycle
	resetClearsState: assert property (@(posedge clock_i)
		$past(reset_i) |-> (PC_o == '0) && !wbValid_o)
		else noteMismatch("PC_o or wbValid_o not cleared by reset");

	// pc frozen while the loader runs
	pcHeldWhileLoading: assert property (@(posedge clock_i) disable iff (reset_i)
		$past(shiftEn_i) && !$past(reset_i) |-> PC_o == $past(PC_o))
		else noteMismatch("PC_o changed while shiftEn_i was high");

	noExtraResults: assert property (@(posedge clock_i) disable iff (reset_i)
		wbValid_o |-> headIdx < expCount)
		else noteFailure("the DUT produced more results than the model expects");

	resultMatchesModel: assert property (@(posedge clock_i) disable iff (reset_i)
		wbValid_o && headIdx < expCount |-> wbLane_o[0] == expLane[headIdx]
			&& wbAddr_o == expAddr[headIdx] && wbData_o == expData[headIdx]
			&& wbStatus_o == expStatus[headIdx])
	else
	begin
		errors++;
		// fields are lane/reg/data/status
		$display("Mismatch at %0t: result %0d got %0d/%0d/%h/%0d, expected %0d/%0d/%h/%0d",
			$time, $sampled(headIdx), $sampled(wbLane_o), $sampled(wbAddr_o),
			$sampled(wbData_o), $sampled(wbStatus_o),
			expLane[$sampled(headIdx)], expAddr[$sampled(headIdx)],
			expData[$sampled(headIdx)], expStatus[$sampled(headIdx)]);
	end

	// head of the list, stall and status counters
	always @(posedge clock_i)
	begin
		if (reset_i)
		begin
			headIdx <= 0;
			stallCycles <= 0;
			ovfSeen <= 0;
			brwSeen <= 0;
		end
		else
		begin
			if (wbValid_o)
			begin
				headIdx <= headIdx + 1;
				if (wbStatus_o == STATUS_OVERFLOW)
					ovfSeen <= ovfSeen + 1;
				if (wbStatus_o == STATUS_UNDERFLOW)
					brwSeen <= brwSeen + 1;
			end
			// pc held although fetch is not loading
			if (!shiftEn_i && !prevShift && PC_o == lastPc)
				stallCycles <= stallCycles + 1;
		end
		lastPc <= PC_o;
		prevShift <= shiftEn_i;
	end

	//////////////////////////////
	// stimulus helpers
	//////////////////////////////
	task automatic nextCycle();
		@(posedge clock_i);
		#1;
	endtask

	function automatic logic [INSTR_WIDTH-1:0] encodeSlot(input logic valid, input logic immFmt,
		input logic [6:0] op, input logic [4:0] prim, input logic [15:0] sec);
		// bits 22:21 unused
		return {valid, immFmt, op, 2'b00, prim, sec};
	endfunction

	function automatic logic [15:0] randImm();
		return 16'($urandom());
	endfunction

	task automatic clearProgram();
		for (int b = 0; b < 8; b++)
			prog[b] = '0;
	endtask

	task automatic applyReset();
		reset_i = 1'b1;
		shiftEn_i = 1'b1;
		isAddress_i = 1'b0;
		shiftOutEn_i = 1'b0;
		repeat (16) nextCycle();
		reset_i = 1'b0;
	endtask

	// address byte, 32 data bytes lowest first, then commit
	task automatic loadLine(input int lineIdx);
		logic [LINE_WIDTH-1:0] lineBits;
		lineBits = {prog[4*lineIdx+3], prog[4*lineIdx+2], prog[4*lineIdx+1], prog[4*lineIdx]};
		shiftEn_i = 1'b1;
		isAddress_i = 1'b1;
		shiftData_i = 8'(lineIdx);
		nextCycle();
		isAddress_i = 1'b0;
		for (int k = 0; k < LINE_BYTES; k++)
		begin
			shiftData_i = lineBits[8*k +: 8];
			nextCycle();
		end
		// address again, so the commit cycle shifts no data in
		isAddress_i = 1'b1;
		shiftData_i = 8'(lineIdx);
		shiftOutEn_i = 1'b1;
		nextCycle();
		shiftOutEn_i = 1'b0;
	endtask

	//////////////////////////////
	// reference model
	//////////////////////////////
	task automatic buildExpected();
		logic [15:0] bank [2][32];
		logic [31:0] s;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] r;
		logic [4:0] p;
		logic ovf;
		logic brw;
		logic writes;
		int sr;
		expCount = 0;
		for (int ln = 0; ln < 2; ln++)
		begin
			for (int i = 0; i < 32; i++)
				bank[ln][i] = '0;
		end
		for (int bi = 0; bi < 8; bi++)
		begin
			for (int ln = 0; ln < 2; ln++)
			begin
				s = prog[bi][ln*32 +: 32];
				p = s[20:16];
				a = bank[ln][p];
				// immediate or source register in the low bits
				b = s[30] ? s[15:0] : bank[ln][s[4:0]];
				r = '0;
				ovf = 1'b0;
				brw = 1'b0;
				writes = s[31];
				case (s[29:23])
					OP_ADD:
					begin
						r = a + b;
						sr = int'($signed(a)) + int'($signed(b));
						ovf = (sr > 32767) || (sr < -32768);
					end
					OP_SUB:
					begin
						r = a - b;
						sr = int'($signed(a)) - int'($signed(b));
						ovf = (sr > 32767) || (sr < -32768);
						brw = a < b;
					end
					OP_AND: r = a & b;
					OP_OR: r = a | b;
					OP_XOR: r = a ^ b;
					OP_MOVE: r = b;
					default: writes = 1'b0;
				endcase
				if (writes)
				begin
					bank[ln][p] = r;
					expLane[expCount] = ln[0];
					expAddr[expCount] = p;
					expData[expCount] = r;
					// overflow is code 2, borrow code 1
					expStatus[expCount] = {ovf, brw};
					expCount++;
				end
			end
		end
	endtask

	//////////////////////////////
	// programs
	//////////////////////////////
	task automatic buildLaneZeroImm();
		clearProgram();
		// moves into r1..r4, then adds on top, lane 1 invalid
		for (int b = 0; b < 8; b++)
			prog[b] = {32'h0, encodeSlot(1'b1, 1'b1, (b < 4) ? OP_MOVE : OP_ADD,
				5'(b % 4 + 1), randImm())};
	endtask

	task automatic buildLaneOneRegs();
		logic [6:0] ops [6];
		logic [4:0] p;
		logic [31:0] s1;
		ops = '{OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SUB, OP_XOR};
		clearProgram();
		for (int b = 0; b < 8; b++)
		begin
			p = 5'(b % 2 + 1);
			// r1 and r2 loaded first, then reg-reg ops between them
			s1 = (b < 2) ? encodeSlot(1'b1, 1'b1, OP_MOVE, p, randImm())
				: encodeSlot(1'b1, 1'b0, ops[b-2], p, 16'(3 - p));
			prog[b] = {s1, encodeSlot(1'b1, 1'b1, OP_NOP, p, randImm())};
		end
	endtask

	task automatic buildBothLanes();
		logic [6:0] ops [6];
		logic [4:0] p;
		logic fmt;
		logic [31:0] s [2];
		ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SUB};
		clearProgram();
		for (int b = 0; b < 8; b++)
		begin
			for (int ln = 0; ln < 2; ln++)
			begin
				p = 5'((b + ln) % 2 + 1);
				fmt = (b < 2) || (b % 2 == 0);
				s[ln] = encodeSlot(1'b1, fmt, (b < 2) ? OP_MOVE : ops[b-2], p,
					fmt ? randImm() : 16'(3 - p));
			end
			prog[b] = {s[1], s[0]};
		end
	endtask

	task automatic buildStatusCases();
		clearProgram();
		prog[0] = {encodeSlot(1'b1, 1'b1, OP_MOVE, 5'd2, 16'd3),
			encodeSlot(1'b1, 1'b1, OP_MOVE, 5'd1, 16'h7fff)};
		// borrow in lane 1, signed overflow in lane 0
		prog[1] = {encodeSlot(1'b1, 1'b1, OP_SUB, 5'd2, 16'd5),
			encodeSlot(1'b1, 1'b1, OP_ADD, 5'd1, 16'd1)};
		prog[2] = {encodeSlot(1'b1, 1'b1, OP_ADD, 5'd2, 16'h8000),
			encodeSlot(1'b1, 1'b1, OP_SUB, 5'd1, 16'd1)};
		prog[3] = {encodeSlot(1'b1, 1'b0, OP_SUB, 5'd2, 16'd1),
			encodeSlot(1'b1, 1'b1, OP_ADD, 5'd1, randImm())};
	endtask

	task automatic buildNopSlots();
		clearProgram();
		prog[0] = {encodeSlot(1'b1, 1'b1, 7'h55, 5'd4, randImm()),
			encodeSlot(1'b1, 1'b1, OP_MOVE, 5'd1, randImm())};
		prog[1] = {encodeSlot(1'b0, 1'b1, OP_ADD, 5'd1, randImm()),
			encodeSlot(1'b1, 1'b1, OP_NOP, 5'd1, randImm())};
		prog[2] = {encodeSlot(1'b1, 1'b1, OP_MOVE, 5'd3, randImm()),
			encodeSlot(1'b0, 1'b1, OP_MOVE, 5'd1, randImm())};
		prog[3] = {encodeSlot(1'b1, 1'b0, OP_NOP, 5'd3, 16'd3),
			encodeSlot(1'b1, 1'b1, 7'h7f, 5'd1, randImm())};
		// r1 must still hold the first move
		prog[4] = {32'h0, encodeSlot(1'b1, 1'b0, OP_ADD, 5'd1, 16'd1)};
	endtask

	task automatic runTest(input string name, input bit needStall, input bit needStatus);
		int errorsBefore;
		int waited;
		errorsBefore = errors;
		buildExpected();
		applyReset();
		loadLine(0);
		loadLine(1);
		repeat (2) nextCycle();
		isAddress_i = 1'b0;
		shiftEn_i = 1'b0;
		waited = 0;
		while (headIdx < expCount && waited < 200)
		begin
			nextCycle();
			waited++;
		end
		if (headIdx < expCount)
			noteFailure($sformatf("timed out with %0d of %0d results", headIdx, expCount));
		waited = 0;
		// run on through empty bundles to catch late extras
		while (PC_o < 16'd24 && waited < 200)
		begin
			nextCycle();
			waited++;
		end
		if (PC_o < 16'd24)
			noteFailure("timed out waiting for fetch to run past the program");
		assert (headIdx == expCount)
			else noteMismatch($sformatf("got %0d results but %0d were expected",
				headIdx, expCount));
		assert (!needStall || stallCycles > 0)
			else noteFailure("fetch never paused under queue back-pressure");
		assert (!needStatus || (ovfSeen > 0 && brwSeen > 0))
			else noteFailure("overflow or borrow status was never reported");
		nTests++;
		if (errors == errorsBefore)
			passed++;
		$display("test %0d %s: %0d results, %0d stall cycles, %s", nTests, name, headIdx,
			stallCycles, (errors == errorsBefore) ? "ok" : "failed");
	endtask

	initial
	begin
		void'($urandom(82954));
		reset_i = 1'b1;
		shiftEn_i = 1'b1;
		shiftData_i = 8'h00;
		isAddress_i = 1'b0;
		shiftOutEn_i = 1'b0;
		buildLaneZeroImm();
		runTest("immediate moves and adds in lane 0", 1'b0, 1'b0);
		buildLaneOneRegs();
		runTest("register ops in lane 1", 1'b0, 1'b0);
		buildBothLanes();
		runTest("both lanes every bundle", 1'b1, 1'b0);
		buildStatusCases();
		runTest("overflow and borrow status", 1'b0, 1'b1);
		buildNopSlots();
		runTest("nop and invalid slots", 1'b0, 1'b0);
		$display("%0d of %0d tests passed, %0d errors", passed, nTests, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// File: vlog.f
logic/paPkg.sv
logic/cacheLoader.sv
logic/instrCache.sv
logic/bundleFetch.sv
logic/execLane.sv
logic/writebackQueue.sv
logic/paCore.sv
tests/paCoreTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= paCoreTb
FILELIST ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= TB PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
